// File: build.f
rtl/chop_pkg.sv
rtl/burst_ctrl.sv
rtl/stream_chop.sv
rtl/burst_tally.sv
rtl/chop_top.sv
sim/chop_top_chk.sv
sim/tb_chop_top.sv

// File: rtl/burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module burst_ctrl (
  input  wire                         clock,
  input  wire                         arst_n_i,
  // command strobe and length, 0 means MAX_LEN
  input  wire                         cmd_valid_i,
  input  wire [chop_pkg::LEN_W-1:0]   cmd_len_i,
  // end of burst from the tally stage
  input  wire                         done_i,
  // chop stage has taken its last input beat
  input  wire                         final_i,
  // enable and length for the chop stage
  output logic                        active_o,
  output logic [chop_pkg::LEN_W-1:0]  len_o,
  output logic                        busy_o
);

  chop_pkg::ctrl_state_e       state_q;
  chop_pkg::ctrl_state_e       state_d;
  logic [chop_pkg::LEN_W-1:0]  len_q;
  logic                        cmd_take;

  // commands only land while idle, anything else is dropped
  assign cmd_take = cmd_valid_i && (state_q == chop_pkg::IDLE);

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      chop_pkg::IDLE: begin
        if (cmd_take) begin
          state_d = chop_pkg::RUN;
        end
      end
      chop_pkg::RUN: begin
        // input side closed, now wait for the output to drain
        if (final_i) begin
          state_d = chop_pkg::CLOSE;
        end
      end
      chop_pkg::CLOSE: begin
        if (done_i) begin
          state_d = chop_pkg::IDLE;
        end
      end
      default: begin
        state_d = chop_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= chop_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // length is latched with the command and held for the whole burst
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      len_q <= (chop_pkg::LEN_W)'(chop_pkg::MAX_LEN);
    end else if (cmd_take) begin
      if (cmd_len_i == '0) begin
        len_q <= (chop_pkg::LEN_W)'(chop_pkg::MAX_LEN);
      end else begin
        len_q <= cmd_len_i;
      end
    end
  end

  // active drops in the done cycle itself so the chop stage clears
  // on the same edge that takes the controller back to idle
  assign active_o = (state_q != chop_pkg::IDLE) && !done_i;

  // busy covers the done cycle too, it falls one edge after active
  assign busy_o = (state_q != chop_pkg::IDLE);

  assign len_o = len_q;

endmodule

`default_nettype wire

// File: rtl/burst_tally.sv
`timescale 1ns/1ps
`default_nettype none

module burst_tally (
  input  wire                       clock,
  input  wire                       arst_n_i,
  // watches the output transfer of the chop stage
  input  wire                       m_valid_i,
  input  wire                       m_ready_i,
  input  wire chop_pkg::beat_t      m_beat_i,
  // end of burst report
  output logic                      done_o,
  output chop_pkg::burst_status_t   status_o
);

  logic [chop_pkg::LEN_W-1:0]  beats_q;
  logic [chop_pkg::SUM_W-1:0]  sum_q;
  logic [chop_pkg::LEN_W-1:0]  beats_nxt;
  logic [chop_pkg::SUM_W-1:0]  sum_nxt;
  logic                        done_q;
  chop_pkg::burst_status_t     status_q;
  logic                        m_take;

  // a beat leaves the chop stage
  assign m_take = m_valid_i && m_ready_i;

  // totals including the current beat
  assign beats_nxt = beats_q + (chop_pkg::LEN_W)'(1);
  // byte sum wraps at SUM_W
  assign sum_nxt   = sum_q + (chop_pkg::SUM_W)'(m_beat_i.data);

  // running count and sum
  // restart from zero after the closing beat of each burst
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beats_q <= '0;
      sum_q   <= '0;
    end else if (m_take) begin
      if (m_beat_i.last) begin
        beats_q <= '0;
        sum_q   <= '0;
      end else begin
        beats_q <= beats_nxt;
        sum_q   <= sum_nxt;
      end
    end
  end

  // done is a single pulse one edge after the closing transfer
  // status keeps its value until the next done
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q   <= 1'b0;
      status_q <= '0;
    end else begin
      done_q <= m_take && m_beat_i.last;
      if (m_take && m_beat_i.last) begin
        status_q.beats <= beats_nxt;
        status_q.sum   <= sum_nxt;
      end
    end
  end

  assign done_o   = done_q;
  assign status_o = status_q;

endmodule

`default_nettype wire

// File: rtl/chop_pkg.sv
`default_nettype none

package chop_pkg;

  // width of one stream beat
  localparam int unsigned DATA_W = 8;

  // longest burst a single command can ask for
  localparam int unsigned MAX_LEN = 64;

  // length and count width, wide enough to hold MAX_LEN itself
  localparam int unsigned LEN_W = $clog2(MAX_LEN + 1);

  // width of the burst byte sum, wraps modulo 2^16
  localparam int unsigned SUM_W = 16;

  // one stream beat, used on both sides of the chop stage
  typedef struct packed {
    // payload byte
    logic [DATA_W-1:0] data;
    // end of frame upstream, end of burst downstream
    logic              last;
  } beat_t;

  // report of one finished burst
  typedef struct packed {
    // number of beats that left on the output
    logic [LEN_W-1:0] beats;
    // sum of the data bytes of those beats
    logic [SUM_W-1:0] sum;
  } burst_status_t;

  // burst controller states
  // IDLE   waiting for a command, commands are taken here only
  // RUN    chop stage enabled, input still open
  // CLOSE  input closed, waiting for the last beat to drain
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    CLOSE = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/chop_top.sv
`timescale 1ns/1ps
`default_nettype none

module chop_top (
  input  wire                         clock,
  input  wire                         arst_n_i,
  // command port
  input  wire                         cmd_valid_i,
  input  wire [chop_pkg::LEN_W-1:0]   cmd_len_i,
  output logic                        busy_o,
  // upstream byte stream
  input  wire                         s_valid_i,
  output logic                        s_ready_o,
  input  wire chop_pkg::beat_t        s_beat_i,
  // chopped output stream
  output logic                        m_valid_o,
  input  wire                         m_ready_i,
  output chop_pkg::beat_t             m_beat_o,
  // burst report
  output logic                        done_o,
  output chop_pkg::burst_status_t     status_o
);

  // controller to chop stage
  logic                        chop_active;
  logic [chop_pkg::LEN_W-1:0]  chop_len;
  // chop stage back to controller
  logic                        chop_final;

  burst_ctrl u_burst_ctrl (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_len_i   (cmd_len_i),
    .done_i      (done_o),
    .final_i     (chop_final),
    .active_o    (chop_active),
    .len_o       (chop_len),
    .busy_o      (busy_o)
  );

  stream_chop u_stream_chop (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .active_i  (chop_active),
    .len_i     (chop_len),
    .s_valid_i (s_valid_i),
    .s_ready_o (s_ready_o),
    .s_beat_i  (s_beat_i),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_beat_o  (m_beat_o),
    .final_o   (chop_final)
  );

  // tally sees the same output transfer as the downstream sink
  burst_tally u_burst_tally (
    .clock     (clock),
    .arst_n_i  (arst_n_i),
    .m_valid_i (m_valid_o),
    .m_ready_i (m_ready_i),
    .m_beat_i  (m_beat_o),
    .done_o    (done_o),
    .status_o  (status_o)
  );

endmodule

`default_nettype wire

// File: rtl/stream_chop.sv
`timescale 1ns/1ps
`default_nettype none

module stream_chop (
  input  wire                         clock,
  input  wire                         arst_n_i,
  // burst enable and length from the controller
  input  wire                         active_i,
  input  wire [chop_pkg::LEN_W-1:0]   len_i,
  // upstream
  input  wire                         s_valid_i,
  output logic                        s_ready_o,
  input  wire chop_pkg::beat_t        s_beat_i,
  // downstream
  output logic                        m_valid_o,
  input  wire                         m_ready_i,
  output chop_pkg::beat_t             m_beat_o,
  // last input beat of the burst has been taken
  output logic                        final_o
);

  // registered handshake flags
  logic                        s_ready_q;
  logic                        m_valid_q;
  logic                        t_valid_q;
  logic                        s_ready_d;
  logic                        m_valid_d;
  logic                        t_valid_d;

  // output register and skid register
  chop_pkg::beat_t             m_beat_q;
  chop_pkg::beat_t             t_beat_q;
  // input beat with its last flag replaced by the chop decision
  chop_pkg::beat_t             s_beat_tag;

  // burst progress
  logic [chop_pkg::LEN_W-1:0]  count_q;
  logic [chop_pkg::LEN_W-1:0]  count_nxt;
  logic                        final_q;
  logic                        tag_last;

  logic                        s_take;
  logic                        m_stall;

  // beat accepted from upstream this cycle
  assign s_take = s_valid_i && s_ready_q;

  // output register full and not leaving
  assign m_stall = m_valid_q && !m_ready_i;

  // beats taken so far including the current one
  assign count_nxt = count_q + (chop_pkg::LEN_W)'(1);

  // burst ends on the len_i-th beat or on an upstream frame end,
  // whichever comes first
  assign tag_last = (count_nxt == len_i) || s_beat_i.last;

  always_comb begin
    s_beat_tag      = s_beat_i;
    s_beat_tag.last = tag_last;
  end

  // beat counter and final flag
  // both clear while the controller holds the stage inactive
  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
      final_q <= 1'b0;
    end else if (!active_i) begin
      count_q <= '0;
      final_q <= 1'b0;
    end else if (s_take) begin
      count_q <= count_nxt;
      if (tag_last) begin
        final_q <= 1'b1;
      end
    end
  end

  // skid holds a beat only when one came in while the output stalled,
  // it empties as soon as the output register moves
  always_comb begin
    if (t_valid_q) begin
      t_valid_d = !m_ready_i;
    end else begin
      t_valid_d = s_take && m_stall;
    end
  end

  // output stays full while stalled, otherwise refills from the skid
  // first and then straight from the input
  assign m_valid_d = m_stall || t_valid_q || s_take;

  // ready is registered, so it must already be low once the skid is
  // about to fill, that keeps a third beat out
  // the closing beat also drops ready in the same edge it is taken
  assign s_ready_d = active_i && !final_q && !(s_take && tag_last) && !t_valid_d;

  always_ff @(posedge clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_ready_q <= 1'b0;
      m_valid_q <= 1'b0;
      t_valid_q <= 1'b0;
    end else begin
      s_ready_q <= s_ready_d;
      m_valid_q <= m_valid_d;
      t_valid_q <= t_valid_d;
    end
  end

  // datapath
  // output valid is not tied to active_i, so a beat already in the
  // output register still completes its transfer after the burst ends
  always_ff @(posedge clock) begin
    if (!m_stall) begin
      if (t_valid_q) begin
        m_beat_q <= t_beat_q;
      end else if (s_take) begin
        m_beat_q <= s_beat_tag;
      end
    end
    // park the incoming beat while the output is blocked
    if (s_take && m_stall) begin
      t_beat_q <= s_beat_tag;
    end
  end

  assign s_ready_o = s_ready_q;
  assign m_valid_o = m_valid_q;
  assign m_beat_o  = m_beat_q;
  assign final_o   = final_q;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# build the testbench with assertions enabled
verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_chop_top \
  -Mdir obj_dir

# run and keep the output for the pass search
out="$(./obj_dir/Vtb_chop_top || true)"
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: sim/chop_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module chop_top_chk (
  input wire                   clock,
  input wire                   arst_n_i,
  input wire                   busy_i,
  input wire                   s_ready_i,
  input wire                   m_valid_i,
  input wire                   m_ready_i,
  input wire chop_pkg::beat_t  m_beat_i,
  input wire                   done_i
);

  // output beat and valid hold while the sink stalls
  stall_hold: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_beat_i))
  ) else $error("output beat or valid changed while stalled");

  // input side only opens inside a burst
  ready_in_burst: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    s_ready_i |-> busy_i
  ) else $error("s_ready_o high while busy_o low");

  // done lasts a single cycle
  done_pulse: assert property (
    @(posedge clock) disable iff (!arst_n_i)
    done_i |=> !done_i
  ) else $error("done_o high for more than one cycle");

endmodule

bind chop_top chop_top_chk u_chop_top_chk (
  .clock     (clock),
  .arst_n_i  (arst_n_i),
  .busy_i    (busy_o),
  .s_ready_i (s_ready_o),
  .m_valid_i (m_valid_o),
  .m_ready_i (m_ready_i),
  .m_beat_i  (m_beat_o),
  .done_i    (done_o)
);

`default_nettype wire

// File: sim/tb_chop_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_chop_top;

  localparam int NUM_BURSTS    = 200;
  localparam int STREAM_BEATS  = 6000;
  localparam int DONE_TIMEOUT  = 3000;

  // clock, reset and all DUT inputs start at known values
  logic                        clock       = 1'b0;
  logic                        arst_n_i    = 1'b0;
  logic                        cmd_valid_i = 1'b0;
  logic [chop_pkg::LEN_W-1:0]  cmd_len_i   = '0;
  logic                        s_valid_i   = 1'b0;
  chop_pkg::beat_t             s_beat_i    = '0;
  logic                        m_ready_i   = 1'b0;
  logic                        busy_o;
  logic                        s_ready_o;
  logic                        m_valid_o;
  chop_pkg::beat_t             m_beat_o;
  logic                        done_o;
  chop_pkg::burst_status_t     status_o;

  int seed = 86;
  // upstream frames planned ahead
  // stream_last marks the end of each frame
  logic [chop_pkg::DATA_W-1:0] stream_data [$];
  logic                        stream_last [$];
  // every beat that really went upstream, in order
  logic [chop_pkg::DATA_W-1:0] sent_data [$];
  logic                        sent_last [$];
  int src_pos       = 0;
  int out_idx       = 0;
  int burst_pos     = 0;
  int beat_in_burst = 0;
  int bursts_done   = 0;
  // length of the burst in flight
  int cur_len       = 1;

  always #5 clock = ~clock;

  chop_top u_chop_top (
    .clock       (clock),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_len_i   (cmd_len_i),
    .busy_o      (busy_o),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .s_beat_i    (s_beat_i),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_beat_o    (m_beat_o),
    .done_o      (done_o),
    .status_o    (status_o)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  // random frames of 1 to 20 beats
  task automatic build_stream();
    int flen;
    while (stream_data.size() < STREAM_BEATS) begin
      flen = rand_range(1, 20);
      for (int i = 0; i < flen; i++) begin
        stream_data.push_back((chop_pkg::DATA_W)'(rand_range(0, 255)));
        stream_last.push_back(i == flen - 1);
      end
    end
  endtask

  // burst from pos ends at len beats or at the frame end if that comes first
  // sum wraps at the status width
  function automatic chop_pkg::burst_status_t expected_burst(input int len, input int pos);
    chop_pkg::burst_status_t res;
    int n;
    int total;
    n = 0;
    total = 0;
    while (n < len && pos + n < sent_data.size()) begin
      total = total + int'(sent_data[pos + n]);
      n = n + 1;
      if (sent_last[pos + n - 1]) begin
        break;
      end
    end
    res.beats = (chop_pkg::LEN_W)'(n);
    res.sum   = (chop_pkg::SUM_W)'(total);
    return res;
  endfunction

  task automatic check_idle_outputs(input string when_txt);
    assert (!s_ready_o && !m_valid_o && !busy_o && !done_o)
      else stop_on_error($sformatf("MISMATCH time %0t: outputs not low %s", $time, when_txt));
  endtask

  // stray commands while busy must be dropped by the controller
  task automatic run_until_done();
    int cycles;
    cycles = 0;
    while (!done_o) begin
      cmd_valid_i <= busy_o && (rand_range(0, 7) == 0);
      cmd_len_i   <= (chop_pkg::LEN_W)'(rand_range(1, 24));
      @(posedge clock);
      cycles++;
      if (cycles > DONE_TIMEOUT) begin
        stop_on_error("timeout waiting for done_o at the end of a burst");
      end
    end
    cmd_valid_i <= 1'b0;
  endtask

  // upstream source and downstream sink
  // an offered beat is held until taken
  // gaps fall only between beats
  always @(posedge clock) begin
    if (!arst_n_i) begin
      s_valid_i <= 1'b0;
      m_ready_i <= 1'b0;
    end else begin
      if (s_valid_i && s_ready_o) begin
        sent_data.push_back(s_beat_i.data);
        sent_last.push_back(s_beat_i.last);
        src_pos = src_pos + 1;
      end
      if (!s_valid_i || s_ready_o) begin
        if (rand_range(0, 3) != 0 && src_pos < stream_data.size()) begin
          s_valid_i     <= 1'b1;
          s_beat_i.data <= stream_data[src_pos];
          s_beat_i.last <= stream_last[src_pos];
        end else begin
          s_valid_i <= 1'b0;
        end
      end
      m_ready_i <= (rand_range(0, 3) != 0);
    end
  end

  // compare every output beat and every done pulse
  always @(posedge clock) begin : compare_outputs
    chop_pkg::burst_status_t exp;
    logic                    exp_last;
    if (arst_n_i) begin
      if (m_valid_o && m_ready_i) begin
        assert (out_idx < sent_data.size())
          else stop_on_error("an output beat appeared that was never sent upstream");
        assert (m_beat_o.data == sent_data[out_idx])
          else stop_on_error($sformatf("MISMATCH time %0t: beat %0d data %h expected %h",
                                       $time, out_idx, m_beat_o.data, sent_data[out_idx]));
        // last on the len-th beat of the burst or on the frame end
        exp_last = ((beat_in_burst + 1) == cur_len) || sent_last[out_idx];
        assert (m_beat_o.last == exp_last)
          else stop_on_error($sformatf("MISMATCH time %0t: beat %0d last %b expected %b",
                                       $time, out_idx, m_beat_o.last, exp_last));
        out_idx = out_idx + 1;
        if (exp_last) begin
          beat_in_burst = 0;
        end else begin
          beat_in_burst = beat_in_burst + 1;
        end
      end
      if (done_o) begin
        exp = expected_burst(cur_len, burst_pos);
        assert (busy_o)
          else stop_on_error("done_o pulsed while busy_o was already low");
        assert (out_idx == burst_pos + int'(exp.beats))
          else stop_on_error($sformatf("MISMATCH time %0t: %0d beats left, expected %0d",
                                       $time, out_idx - burst_pos, exp.beats));
        assert (status_o == exp)
          else stop_on_error($sformatf("MISMATCH time %0t: status %0d/%h expected %0d/%h",
                                       $time, status_o.beats, status_o.sum, exp.beats, exp.sum));
        burst_pos   = out_idx;
        bursts_done = bursts_done + 1;
      end
    end
  end

  initial begin
    build_stream();
    repeat (2) @(posedge clock);
    check_idle_outputs("during reset");
    arst_n_i <= 1'b1;
    @(posedge clock);
    check_idle_outputs("right after reset");
    for (int b = 0; b < NUM_BURSTS; b++) begin
      cur_len = rand_range(1, 24);
      cmd_valid_i <= 1'b1;
      cmd_len_i   <= (chop_pkg::LEN_W)'(cur_len);
      @(posedge clock);
      run_until_done();
      // busy drops one cycle after the done pulse
      @(posedge clock);
      assert (!busy_o)
        else stop_on_error($sformatf("MISMATCH time %0t: busy_o high one cycle after done_o",
                                     $time));
    end
    @(posedge clock);
    if (out_idx == sent_data.size()) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with %0d bursts checked and %0d of %0d beats out",
                              bursts_done, out_idx, sent_data.size()));
    end
  end

endmodule

`default_nettype wire
